// File: pit_testdata.txt
# All fields hex. T name | W addr byte | K chan ticks gate | R addr expected
# O expected out[2:0] | D expected dout | X reset
T mode0_two_byte
W 3 30
O 0
W 0 03
W 0 01
K 0 1 1
O 0
R 0 03
R 0 01
K 0 102 1
O 0
R 0 01
R 0 00
K 0 1 1
O 1
R 0 00
R 0 00
T mode2_rate
W 3 54
W 1 04
K 1 1 1
O 3
K 1 2 1
O 3
K 1 1 1
O 1
K 1 1 1
O 3
K 1 2 1
O 3
K 1 1 1
O 1
K 1 1 1
O 3
K 1 2 1
O 3
K 1 1 1
O 1
K 1 1 1
O 3
T mode3_square
W 3 96
W 2 06
K 2 1 1
O 7
K 2 2 1
O 7
K 2 1 1
O 3
K 2 2 1
O 3
K 2 1 1
O 7
W 2 05
K 2 1 1
K 2 2 1
O 7
K 2 1 1
O 3
K 2 1 1
O 3
K 2 1 1
O 7
T gate_hold
W 3 30
W 0 10
W 0 00
K 0 1 1
K 0 3 1
K 0 5 0
R 0 0D
R 0 00
K 0 2 1
R 0 0B
R 0 00
O 6
T counter_latch
W 3 00
K 0 4 1
R 0 0B
R 0 00
R 0 07
R 0 00
W 3 10
W 0 34
K 0 1 1
K 0 4 1
W 3 00
K 0 2 1
R 0 30
R 0 2E
O 6
T mode4_strobe
W 3 58
O 6
W 1 03
K 1 1 1
K 1 2 1
O 6
K 1 1 1
O 4
K 1 1 1
O 6
K 1 3 1
O 6
R 1 FC
D FC
X
O 0
D 00

// File: src.f
pit_pkg.sv
pit_bus_decode.sv
pit_count_load.sv
pit_down_counter.sv
pit_out_ctrl.sv
pit_read_latch.sv
pit_channel.sv
pit_top.sv
pit_tb.sv

// File: pit_tb.sv
// Testbench for the interval timer: script reader, bus driver, tick bursts and checks
module pit_tb
  import pit_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 8;
  localparam int LINE_LIMIT = 500;

  logic       WR_ = 1'b0;
  logic       LOAD;
  logic       cs;
  logic       wr;
  logic       rd;
  logic [1:0] addr;
  pit_byte_t  din;
  logic [2:0] cnt_tick;
  logic [2:0] gate;
  pit_byte_t  dout;
  logic [2:0] out;

  integer            seed = 75;
  integer            fd;
  integer            code;
  integer            lines;
  integer            gap;
  integer            errors;
  integer            test_errors;
  integer            tests;
  integer            failed_tests;
  integer            checks;
  reg [8*32-1:0]     test_name;
  reg [8*256-1:0]    skip_text;
  reg [7:0]          kind;
  logic [15:0]       f1;
  logic [15:0]       f2;
  logic [15:0]       f3;
  logic              done;

  pit_top u_pit_top (
    .WR_      (WR_),
    .LOAD     (LOAD),
    .cs       (cs),
    .wr       (wr),
    .rd       (rd),
    .addr     (addr),
    .din      (din),
    .cnt_tick (cnt_tick),
    .gate     (gate),
    .dout     (dout),
    .out      (out)
  );

  always #5 WR_ = ~WR_;

  task automatic check_value(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    checks++;
    if (exp !== act) begin
      $display("MISMATCH test %0s %0s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic close_test();
    if (test_name != 0) begin
      tests++;
      if (test_errors == 0) begin
        $display("test %0s: ok", test_name);
      end else begin
        failed_tests++;
        $display("test %0s: %0d error(s)", test_name, test_errors);
      end
    end
    test_errors = 0;
  endtask

  task automatic bus_write(input logic [1:0] a, input pit_byte_t d);
    cs   = 1'b1;
    wr   = 1'b1;
    addr = a;
    din  = d;
    @(negedge WR_);
    cs = 1'b0;
    wr = 1'b0;
    // Idle cycle so count_ready arms the counter before any tick
    @(negedge WR_);
  endtask

  task automatic bus_read(input logic [1:0] a);
    cs   = 1'b1;
    rd   = 1'b1;
    addr = a;
    @(negedge WR_);
    cs = 1'b0;
    rd = 1'b0;
  endtask

  // One tick per clock, gate left at the given level afterwards
  task automatic tick_burst(input int ch, input int n, input logic g);
    gate[ch] = g;
    for (int i = 0; i < n; i++) begin
      cnt_tick[ch] = 1'b1;
      @(negedge WR_);
    end
    cnt_tick[ch] = 1'b0;
  endtask

  task automatic wait_dout(input logic [15:0] exp);
    int n;
    n = 0;
    while ((dout !== exp[7:0]) && (n < WAIT_LIMIT)) begin
      @(negedge WR_);
      n++;
    end
    if (dout !== exp[7:0]) begin
      $display("ERROR test %0s: timeout waiting for output on dout", test_name);
    end
    check_value("dout", exp, {8'h00, dout});
  endtask

  task automatic wait_out(input logic [15:0] exp);
    int n;
    n = 0;
    while ((out !== exp[2:0]) && (n < WAIT_LIMIT)) begin
      @(negedge WR_);
      n++;
    end
    if (out !== exp[2:0]) begin
      $display("ERROR test %0s: timeout waiting for output on out", test_name);
    end
    check_value("out", exp, {13'h0000, out});
  endtask

  task automatic apply_reset();
    LOAD     = 1'b1;
    cs       = 1'b0;
    wr       = 1'b0;
    rd       = 1'b0;
    cnt_tick = 3'b000;
    repeat (2) @(negedge WR_);
    LOAD = 1'b0;
  endtask

  initial begin
    LOAD         = 1'b1;
    cs           = 1'b0;
    wr           = 1'b0;
    rd           = 1'b0;
    addr         = 2'd0;
    din          = 8'h00;
    cnt_tick     = 3'b000;
    gate         = 3'b000;
    errors       = 0;
    test_errors  = 0;
    tests        = 0;
    failed_tests = 0;
    checks       = 0;
    test_name    = 0;
    repeat (2) @(negedge WR_);
    LOAD = 1'b0;

    fd = $fopen("pit_testdata.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the script file pit_testdata.txt");
      errors++;
    end else begin
      done  = 1'b0;
      lines = 0;
      while (!done && (lines < LINE_LIMIT)) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
          done = 1'b1;
        end else begin
          lines++;
          case (kind)
            "#": code = $fgets(skip_text, fd);
            "T": begin
              close_test();
              code = $fscanf(fd, " %s", test_name);
            end
            "W": begin
              code = $fscanf(fd, " %h %h", f1, f2);
              bus_write(f1[1:0], f2[7:0]);
            end
            "K": begin
              code = $fscanf(fd, " %h %h %h", f1, f2, f3);
              tick_burst(f1, f2, f3[0]);
            end
            "R": begin
              code = $fscanf(fd, " %h %h", f1, f2);
              bus_read(f1[1:0]);
              wait_dout(f2);
            end
            "D": begin
              code = $fscanf(fd, " %h", f1);
              wait_dout(f1);
            end
            "O": begin
              code = $fscanf(fd, " %h", f1);
              wait_out(f1);
            end
            "X": apply_reset();
            default: begin
              $display("ERROR: unknown script line kind '%c'", kind);
              errors++;
            end
          endcase
          if (kind != "#") begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge WR_);
          end
        end
      end
      $fclose(fd);
      close_test();
    end

    $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if ((errors == 0) && (tests > 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: pit_top.sv
// Timer top level: bus decoder, three channels and the registered read data mux
module pit_top
  import pit_pkg::*;
(
  input  logic       WR_,
  input  logic       LOAD,
  input  logic       cs,
  input  logic       wr,
  input  logic       rd,
  input  logic [1:0] addr,
  input  pit_byte_t  din,
  input  logic [2:0] cnt_tick,
  input  logic [2:0] gate,
  output pit_byte_t  dout,
  output logic [2:0] out
);

  pit_cmd_t  cmd [3];
  pit_byte_t rd_byte [3];

  pit_bus_decode u_bus_decode (
    .WR_  (WR_),
    .LOAD (LOAD),
    .cs   (cs),
    .wr   (wr),
    .rd   (rd),
    .addr (addr),
    .din  (din),
    .cmd0 (cmd[0]),
    .cmd1 (cmd[1]),
    .cmd2 (cmd[2])
  );

  for (genvar i = 0; i < 3; i++) begin : g_chan
    pit_channel u_channel (
      .WR_      (WR_),
      .LOAD     (LOAD),
      .cmd      (cmd[i]),
      .cnt_tick (cnt_tick[i]),
      .gate     (gate[i]),
      .out      (out[i]),
      .rd_byte  (rd_byte[i])
    );
  end

  // Read data captured at the end of the read cycle and held
  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      dout <= '0;
    end else if (cs && rd) begin
      case (addr)
        2'd0:    dout <= rd_byte[0];
        2'd1:    dout <= rd_byte[1];
        2'd2:    dout <= rd_byte[2];
        default: dout <= dout;
      endcase
    end
  end

endmodule

// File: pit_channel.sv
// One timer channel: count load, down counter, output control and read latch
module pit_channel
  import pit_pkg::*;
(
  input  logic      WR_,
  input  logic      LOAD,
  input  pit_cmd_t  cmd,
  input  logic      cnt_tick,
  input  logic      gate,
  output logic      out,
  output pit_byte_t rd_byte
);

  pit_mode_e  mode;
  pit_rw_e    rw;
  pit_count_t count_val;
  pit_count_t count;
  logic       count_ready;
  logic       programmed;
  logic       tc_pulse;
  logic       reload_pulse;

  pit_count_load u_count_load (
    .WR_         (WR_),
    .LOAD        (LOAD),
    .cmd         (cmd),
    .mode        (mode),
    .rw          (rw),
    .count_val   (count_val),
    .count_ready (count_ready),
    .programmed  (programmed)
  );

  pit_down_counter u_down_counter (
    .WR_          (WR_),
    .LOAD         (LOAD),
    .cnt_tick     (cnt_tick),
    .gate         (gate),
    .mode         (mode),
    .count_val    (count_val),
    .count_ready  (count_ready),
    .programmed   (programmed),
    .count        (count),
    .tc_pulse     (tc_pulse),
    .reload_pulse (reload_pulse)
  );

  pit_out_ctrl u_out_ctrl (
    .WR_          (WR_),
    .LOAD         (LOAD),
    .mode         (mode),
    .ctrl_wr      (cmd.ctrl_wr),
    .tc_pulse     (tc_pulse),
    .reload_pulse (reload_pulse),
    .out          (out)
  );

  pit_read_latch u_read_latch (
    .WR_     (WR_),
    .LOAD    (LOAD),
    .cmd     (cmd),
    .rw      (rw),
    .count   (count),
    .rd_byte (rd_byte)
  );

endmodule

// File: pit_read_latch.sv
// Counter latch command and read byte sequencing for one channel
module pit_read_latch
  import pit_pkg::*;
(
  input  logic       WR_,
  input  logic       LOAD,
  input  pit_cmd_t   cmd,
  input  pit_rw_e    rw,
  input  pit_count_t count,
  output pit_byte_t  rd_byte
);

  pit_byte_sel_e rd_sel;
  logic          latched;
  logic          read_done;
  pit_count_t    latch_val;
  pit_count_t    src;

  assign src       = latched ? latch_val : count;
  assign read_done = cmd.rd && ((rw != rw_lsb_msb) || (rd_sel == byte_msb));

  always_comb begin
    case (rw)
      rw_lsb:     rd_byte = src[7:0];
      rw_msb:     rd_byte = src[15:8];
      rw_lsb_msb: rd_byte = (rd_sel == byte_lsb) ? src[7:0] : src[15:8];
      default:    rd_byte = 8'h00;
    endcase
  end

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      latched <= 1'b0;
      rd_sel  <= byte_lsb;
    end else if (cmd.ctrl_wr) begin
      latched <= 1'b0;
      rd_sel  <= byte_lsb;
    end else begin
      // Held until the last byte of the latched value is read
      if (cmd.latch_cmd) begin
        latched <= 1'b1;
      end else if (read_done) begin
        latched <= 1'b0;
      end
      if (cmd.rd && (rw == rw_lsb_msb)) begin
        rd_sel <= (rd_sel == byte_lsb) ? byte_msb : byte_lsb;
      end
    end
  end

  // Repeated latch commands keep the first snapshot
  always_ff @(posedge WR_) begin
    if (cmd.latch_cmd && !latched) begin
      latch_val <= count;
    end
  end

endmodule

// File: pit_out_ctrl.sv
// Channel output waveform generator for modes 0, 2, 3 and 4
module pit_out_ctrl
  import pit_pkg::*;
(
  input  logic      WR_,
  input  logic      LOAD,
  input  pit_mode_e mode,
  input  logic      ctrl_wr,
  input  logic      tc_pulse,
  input  logic      reload_pulse,
  output logic      out
);

  // New mode is visible one edge after the control write
  logic init_pend;

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      init_pend <= 1'b0;
    end else begin
      init_pend <= ctrl_wr;
    end
  end

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      out <= 1'b0;
    end else if (init_pend) begin
      // Low in mode 0, high in every other mode
      out <= (mode != mode0);
    end else begin
      case (mode)
        mode0: begin
          if (tc_pulse) begin
            out <= 1'b1;
          end
        end
        mode3: begin
          // Reload coincides with terminal count here
          if (tc_pulse) begin
            out <= ~out;
          end
        end
        mode2, mode4: begin
          if (tc_pulse) begin
            out <= 1'b0;
          end else if (reload_pulse) begin
            out <= 1'b1;
          end
        end
        default: out <= out;
      endcase
    end
  end

endmodule

// File: pit_down_counter.sv
// Channel down counter with deferred load, per-mode step size and reload
module pit_down_counter
  import pit_pkg::*;
(
  input  logic       WR_,
  input  logic       LOAD,
  input  logic       cnt_tick,
  input  logic       gate,
  input  pit_mode_e  mode,
  input  pit_count_t count_val,
  input  logic       count_ready,
  input  logic       programmed,
  output pit_count_t count,
  output logic       tc_pulse,
  output logic       reload_pulse
);

  logic       pending;
  logic       armed;
  logic       strobe_low;
  logic       half_hi;
  logic       load_tick;
  logic       cnt_en;
  pit_count_t step;

  // Load tick ignores gate, count ticks need it
  assign load_tick = cnt_tick && programmed && pending;
  assign cnt_en    = cnt_tick && gate && programmed && !pending;

  // Odd mode 3 counts take one odd step so each half ends on zero
  always_comb begin
    step = 16'd1;
    if (mode == mode3) begin
      if (!count[0]) begin
        step = 16'd2;
      end else if (half_hi) begin
        step = 16'd1;
      end else begin
        step = 16'd3;
      end
    end
  end

  // Count events seen by the output block on the tick that causes them
  always_comb begin
    tc_pulse     = 1'b0;
    reload_pulse = 1'b0;
    case (mode)
      mode0: tc_pulse = cnt_en && armed && (count == 16'd1);
      mode2: begin
        tc_pulse     = cnt_en && (count == 16'd2);
        reload_pulse = cnt_en && (count == 16'd1);
      end
      mode3: begin
        tc_pulse     = cnt_en && (count == step);
        reload_pulse = cnt_en && (count == step);
      end
      mode4: begin
        tc_pulse     = cnt_en && armed && (count == 16'd1);
        // End of the strobe, count wraps and is not reloaded
        reload_pulse = cnt_en && strobe_low;
      end
      default: tc_pulse = 1'b0;
    endcase
  end

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      count      <= '0;
      pending    <= 1'b0;
      armed      <= 1'b0;
      strobe_low <= 1'b0;
      half_hi    <= 1'b1;
    end else begin
      if (count_ready) begin
        pending <= 1'b1;
      end else if (!programmed || load_tick) begin
        pending <= 1'b0;
      end
      if (load_tick) begin
        count      <= count_val;
        armed      <= 1'b1;
        strobe_low <= 1'b0;
        half_hi    <= 1'b1;
      end else if (cnt_en) begin
        if (reload_pulse && (mode != mode4)) begin
          count <= count_val;
        end else begin
          count <= count - step;
        end
        if (tc_pulse) begin
          armed <= 1'b0;
        end
        strobe_low <= tc_pulse && (mode == mode4);
        if ((mode == mode3) && reload_pulse) begin
          half_hi <= ~half_hi;
        end
      end
    end
  end

  // Loaded counts of 2 or more keep mode 3 from stepping below zero
  a_mode3_no_underflow: assert property (
    @(posedge WR_) disable iff (LOAD) (cnt_en && (mode == mode3)) |-> (count >= step)
  );

endmodule

// File: pit_count_load.sv
// Per-channel mode register, count register and write byte-order flip-flop
module pit_count_load
  import pit_pkg::*;
(
  input  logic       WR_,
  input  logic       LOAD,
  input  pit_cmd_t   cmd,
  output pit_mode_e  mode,
  output pit_rw_e    rw,
  output pit_count_t count_val,
  output logic       count_ready,
  output logic       programmed
);

  pit_byte_sel_e wr_sel;
  logic          last_byte;

  // Final byte of the count for the stored byte order
  assign last_byte = cmd.count_wr && (rw != rw_latch) &&
                     ((rw != rw_lsb_msb) || (wr_sel == byte_msb));

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      mode        <= mode0;
      rw          <= rw_latch;
      wr_sel      <= byte_lsb;
      count_ready <= 1'b0;
      programmed  <= 1'b0;
    end else begin
      count_ready <= last_byte;
      if (cmd.ctrl_wr) begin
        // Unsupported modes fall back to mode 0
        case (cmd.ctrl.mode)
          mode2, mode3, mode4: mode <= cmd.ctrl.mode;
          default:             mode <= mode0;
        endcase
        rw         <= cmd.ctrl.rw;
        wr_sel     <= byte_lsb;
        programmed <= 1'b0;
      end else begin
        if (cmd.count_wr && (rw == rw_lsb_msb)) begin
          wr_sel <= (wr_sel == byte_lsb) ? byte_msb : byte_lsb;
        end
        if (last_byte) begin
          programmed <= 1'b1;
        end
      end
    end
  end

  // Count bytes assembled per byte order
  always_ff @(posedge WR_) begin
    if (cmd.count_wr) begin
      case (rw)
        rw_lsb: count_val <= {8'h00, cmd.data};
        rw_msb: count_val <= {cmd.data, 8'h00};
        rw_lsb_msb: begin
          if (wr_sel == byte_lsb) begin
            count_val[7:0] <= cmd.data;
          end else begin
            count_val[15:8] <= cmd.data;
          end
        end
        default: count_val <= count_val;
      endcase
    end
  end

endmodule

// File: pit_bus_decode.sv
// Bus decoder turning cs/wr/rd cycles into per-channel command structs
module pit_bus_decode
  import pit_pkg::*;
(
  input  logic       WR_,
  input  logic       LOAD,
  input  logic       cs,
  input  logic       wr,
  input  logic       rd,
  input  logic [1:0] addr,
  input  pit_byte_t  din,
  output pit_cmd_t   cmd0,
  output pit_cmd_t   cmd1,
  output pit_cmd_t   cmd2
);

  pit_ctrl_t ctrl_word;
  logic      wr_cyc;
  logic      rd_cyc;
  logic      ctrl_cyc;
  pit_cmd_t  cmd [3];

  assign ctrl_word = pit_ctrl_t'(din);
  assign wr_cyc    = cs && wr;
  assign rd_cyc    = cs && rd;
  assign ctrl_cyc  = wr_cyc && (addr == 2'd3);

  // Select field 3 matches no channel, so that word is dropped
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      cmd[i].ctrl_wr   = ctrl_cyc && (ctrl_word.sel == 2'(i)) &&
                         (ctrl_word.rw != rw_latch);
      cmd[i].latch_cmd = ctrl_cyc && (ctrl_word.sel == 2'(i)) &&
                         (ctrl_word.rw == rw_latch);
      cmd[i].count_wr  = wr_cyc && (addr == 2'(i));
      cmd[i].rd        = rd_cyc && (addr == 2'(i));
      cmd[i].ctrl      = ctrl_word;
      cmd[i].data      = din;
    end
  end

  assign cmd0 = cmd[0];
  assign cmd1 = cmd[1];
  assign cmd2 = cmd[2];

  // A bus cycle is either a write or a read
  a_no_wr_rd_overlap: assert property (
    @(posedge WR_) disable iff (LOAD) !(cs && wr && rd)
  );

endmodule

// File: pit_pkg.sv
// Shared types for the interval timer: byte and count widths, control word, channel command, enums
package pit_pkg;

  // One data bus byte
  typedef logic [7:0] pit_byte_t;

  // Counter value
  typedef logic [15:0] pit_count_t;

  // Read/write field of the control word
  typedef enum logic [1:0] {
    rw_latch   = 2'b00,
    rw_lsb     = 2'b01,
    rw_msb     = 2'b10,
    rw_lsb_msb = 2'b11
  } pit_rw_e;

  // Supported counting modes, encoded as in control word bits 3:1
  typedef enum logic [2:0] {
    mode0 = 3'd0,
    mode2 = 3'd2,
    mode3 = 3'd3,
    mode4 = 3'd4
  } pit_mode_e;

  // Control word as written to address 3
  typedef struct packed {
    logic [1:0] sel;
    pit_rw_e    rw;
    pit_mode_e  mode;
    logic       bcd;
  } pit_ctrl_t;

  // Per-channel command from the bus decoder
  typedef struct packed {
    logic      ctrl_wr;
    logic      latch_cmd;
    logic      count_wr;
    logic      rd;
    pit_ctrl_t ctrl;
    pit_byte_t data;
  } pit_cmd_t;

  // Byte order flip-flop for two-byte transfers
  typedef enum logic {
    byte_lsb = 1'b0,
    byte_msb = 1'b1
  } pit_byte_sel_e;

endpackage
